// ==== Makefile ====
# Verilator build and run for the rename and commit back end

VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
src/backend_pkg.sv
src/free_list.sv
src/rename_map.sv
src/dispatch_ctrl.sv
src/rob.sv
src/backend_top.sv
test/tb_backend.sv

// ==== src/backend_pkg.sv ====
package backend_pkg;

    // reorder buffer sizing
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;

    // register file sizing
    localparam int num_phys = 64;
    localparam int phys_w   = 6;
    localparam int arch_w   = 5;
    localparam int num_arch = 32;
    localparam int fl_depth = num_phys - num_arch;  // regs not mapped at reset
    localparam int fl_idx_w = 5;

    // retire record field widths
    localparam int xlen    = 32;
    localparam int order_w = 64;

    localparam logic [xlen-1:0] nop_inst = 32'h13;  // addi x0, x0, 0

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic {
        disp_idle,
        disp_ack
    } dispatch_state_t;

endpackage

// ==== src/backend_top.sv ====
`timescale 1ns/1ps

module backend_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              disp_req,
    input  logic [backend_pkg::xlen-1:0]      inst,
    input  logic [backend_pkg::arch_w-1:0]    rd,
    input  logic [backend_pkg::arch_w-1:0]    rs1,
    input  logic [backend_pkg::arch_w-1:0]    rs2,
    input  logic                              regf_we,
    input  logic [backend_pkg::xlen-1:0]      pc_rdata,
    input  logic [backend_pkg::xlen-1:0]      pc_wdata,
    input  logic [backend_pkg::order_w-1:0]   order,
    output logic                              disp_ack,
    output logic [backend_pkg::rob_idx_w-1:0] disp_rob_idx,
    output logic [backend_pkg::phys_w-1:0]    disp_pd,
    output logic [backend_pkg::phys_w-1:0]    disp_ps1,
    output logic [backend_pkg::phys_w-1:0]    disp_ps2,
    input  logic                              alu_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] alu_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      alu_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      alu_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      alu_rd_wdata,
    input  logic                              mul_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] mul_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      mul_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      mul_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      mul_rd_wdata,
    input  logic                              div_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] div_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      div_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      div_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      div_rd_wdata,
    output logic                              retire_valid,
    output logic [backend_pkg::order_w-1:0]   retire_order,
    output logic [backend_pkg::xlen-1:0]      retire_inst,
    output logic [backend_pkg::arch_w-1:0]    retire_rd_addr,
    output logic [backend_pkg::arch_w-1:0]    retire_rs1_addr,
    output logic [backend_pkg::arch_w-1:0]    retire_rs2_addr,
    output logic [backend_pkg::xlen-1:0]      retire_rd_wdata,
    output logic [backend_pkg::xlen-1:0]      retire_rs1_rdata,
    output logic [backend_pkg::xlen-1:0]      retire_rs2_rdata,
    output logic [backend_pkg::phys_w-1:0]    retire_pd,
    output logic [backend_pkg::xlen-1:0]      retire_pc_rdata,
    output logic [backend_pkg::xlen-1:0]      retire_pc_wdata
);

    logic                              alloc_fire;
    logic                              needs_dest;
    logic                              rob_full;
    logic                              fl_empty;
    logic                              fl_pop;
    logic [backend_pkg::phys_w-1:0]    fl_head_pd;
    logic [backend_pkg::phys_w-1:0]    ps1;
    logic [backend_pkg::phys_w-1:0]    ps2;
    logic [backend_pkg::phys_w-1:0]    map_old_pd;
    logic [backend_pkg::phys_w-1:0]    alloc_pd;
    logic [backend_pkg::phys_w-1:0]    alloc_old_pd;
    logic [backend_pkg::rob_idx_w-1:0] enq_idx;
    logic                              free_valid;
    logic [backend_pkg::phys_w-1:0]    free_pd;

    // no destination means p0 both ways
    assign fl_pop       = alloc_fire && needs_dest;
    assign alloc_pd     = needs_dest ? fl_head_pd : '0;
    assign alloc_old_pd = needs_dest ? map_old_pd : '0;

    dispatch_ctrl u_dispatch_ctrl (.*);

    free_list u_free_list (
        .clk     (clk),
        .rst     (rst),
        .pop     (fl_pop),
        .push    (free_valid),
        .push_pd (free_pd),
        .head_pd (fl_head_pd),
        .empty   (fl_empty)
    );

    rename_map u_rename_map (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .we     (fl_pop),
        .new_pd (fl_head_pd),
        .ps1    (ps1),
        .ps2    (ps2),
        .old_pd (map_old_pd)
    );

    rob u_rob (
        .*,
        .enq    (alloc_fire),
        .pd     (alloc_pd),
        .old_pd (alloc_old_pd),
        .full   (rob_full)
    );

    // held for the dispatcher while ack is up
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            disp_rob_idx <= enq_idx;
            disp_pd      <= alloc_pd;
            disp_ps1     <= ps1;
            disp_ps2     <= ps2;
        end
    end

endmodule

// ==== src/dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           disp_req,
    input  logic [backend_pkg::arch_w-1:0] rd,
    input  logic                           regf_we,
    input  logic                           rob_full,
    input  logic                           fl_empty,
    output logic                           disp_ack,
    output logic                           alloc_fire,
    output logic                           needs_dest
);

    backend_pkg::dispatch_state_t state;

    assign needs_dest = regf_we && (rd != '0);
    assign disp_ack   = (state == backend_pkg::disp_ack);

    // a request waits here until the rob and free list have room
    assign alloc_fire = (state == backend_pkg::disp_idle) && disp_req && !rob_full &&
                        (!needs_dest || !fl_empty);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= backend_pkg::disp_idle;
        end else begin
            case (state)
                backend_pkg::disp_idle: begin
                    if (alloc_fire) state <= backend_pkg::disp_ack;
                end
                backend_pkg::disp_ack: begin
                    if (!disp_req) state <= backend_pkg::disp_idle;  // req dropped, release ack
                end
                default: state <= backend_pkg::disp_idle;
            endcase
        end
    end

    // the dispatcher holds its request until it is acked
    assert property (@(posedge clk) disable iff (rst) disp_req && !disp_ack |=> disp_req)
        else $error("dispatch request dropped before ack");

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/1ps

module free_list (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pop,
    input  logic                           push,
    input  logic [backend_pkg::phys_w-1:0] push_pd,
    output logic [backend_pkg::phys_w-1:0] head_pd,
    output logic                           empty
);

    logic [backend_pkg::phys_w-1:0] mem [backend_pkg::fl_depth];
    logic [backend_pkg::fl_idx_w:0] head_ptr;  // top bit is the wrap flag
    logic [backend_pkg::fl_idx_w:0] tail_ptr;

    assign head_pd = mem[head_ptr[backend_pkg::fl_idx_w-1:0]];
    assign empty   = (head_ptr == tail_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            // starts full with the regs above the arch range
            for (int i = 0; i < backend_pkg::fl_depth; i++) begin
                mem[i] <= backend_pkg::phys_w'(backend_pkg::num_arch + i);
            end
            head_ptr <= '0;
            tail_ptr <= {1'b1, {backend_pkg::fl_idx_w{1'b0}}};
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push) begin
                mem[tail_ptr[backend_pkg::fl_idx_w-1:0]] <= push_pd;
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

    // dispatch must check empty before allocating
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free list popped while empty");

endmodule

// ==== src/rename_map.sv ====
`timescale 1ns/1ps

module rename_map (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [backend_pkg::arch_w-1:0] rs1,
    input  logic [backend_pkg::arch_w-1:0] rs2,
    input  logic [backend_pkg::arch_w-1:0] rd,
    input  logic                           we,
    input  logic [backend_pkg::phys_w-1:0] new_pd,
    output logic [backend_pkg::phys_w-1:0] ps1,
    output logic [backend_pkg::phys_w-1:0] ps2,
    output logic [backend_pkg::phys_w-1:0] old_pd
);

    logic [backend_pkg::phys_w-1:0] map [backend_pkg::num_arch];

    // reads see the table before this cycle's write
    assign ps1    = map[rs1];
    assign ps2    = map[rs2];
    assign old_pd = map[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < backend_pkg::num_arch; i++) begin
                map[i] <= backend_pkg::phys_w'(i);  // identity
            end
        end else if (we && rd != '0) begin  // x0 stays on p0
            map[rd] <= new_pd;
        end
    end

endmodule

// ==== src/rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enq,
    input  logic [backend_pkg::phys_w-1:0]    pd,
    input  logic [backend_pkg::phys_w-1:0]    old_pd,
    input  logic [backend_pkg::arch_w-1:0]    rd,
    input  logic [backend_pkg::arch_w-1:0]    rs1,
    input  logic [backend_pkg::arch_w-1:0]    rs2,
    input  logic [backend_pkg::xlen-1:0]      inst,
    input  logic [backend_pkg::xlen-1:0]      pc_rdata,
    input  logic [backend_pkg::xlen-1:0]      pc_wdata,
    input  logic [backend_pkg::order_w-1:0]   order,
    input  logic                              alu_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] alu_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      alu_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      alu_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      alu_rd_wdata,
    input  logic                              mul_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] mul_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      mul_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      mul_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      mul_rd_wdata,
    input  logic                              div_cdb_valid,
    input  logic [backend_pkg::rob_idx_w-1:0] div_rob_idx,
    input  logic [backend_pkg::xlen-1:0]      div_rs1_rdata,
    input  logic [backend_pkg::xlen-1:0]      div_rs2_rdata,
    input  logic [backend_pkg::xlen-1:0]      div_rd_wdata,
    output logic                              full,
    output logic [backend_pkg::rob_idx_w-1:0] enq_idx,
    output logic                              retire_valid,
    output logic [backend_pkg::order_w-1:0]   retire_order,
    output logic [backend_pkg::xlen-1:0]      retire_inst,
    output logic [backend_pkg::arch_w-1:0]    retire_rd_addr,
    output logic [backend_pkg::arch_w-1:0]    retire_rs1_addr,
    output logic [backend_pkg::arch_w-1:0]    retire_rs2_addr,
    output logic [backend_pkg::xlen-1:0]      retire_rd_wdata,
    output logic [backend_pkg::xlen-1:0]      retire_rs1_rdata,
    output logic [backend_pkg::xlen-1:0]      retire_rs2_rdata,
    output logic [backend_pkg::phys_w-1:0]    retire_pd,
    output logic [backend_pkg::xlen-1:0]      retire_pc_rdata,
    output logic [backend_pkg::xlen-1:0]      retire_pc_wdata,
    output logic                              free_valid,
    output logic [backend_pkg::phys_w-1:0]    free_pd
);

    localparam int n = backend_pkg::rob_depth;

    logic [backend_pkg::rob_idx_w:0]   head_ptr;  // wrap bit on top
    logic [backend_pkg::rob_idx_w:0]   tail_ptr;
    logic [backend_pkg::rob_idx_w-1:0] head_idx;
    logic [n-1:0]                      valid_q;
    logic [n-1:0]                      commit_q;

    // entry payload
    logic [backend_pkg::phys_w-1:0]  pd_q       [n];
    logic [backend_pkg::phys_w-1:0]  old_pd_q   [n];
    logic [backend_pkg::arch_w-1:0]  rd_q       [n];
    logic [backend_pkg::arch_w-1:0]  rs1_q      [n];
    logic [backend_pkg::arch_w-1:0]  rs2_q      [n];
    logic [backend_pkg::xlen-1:0]    inst_q     [n];
    logic [backend_pkg::xlen-1:0]    pc_rdata_q [n];
    logic [backend_pkg::xlen-1:0]    pc_wdata_q [n];
    logic [backend_pkg::order_w-1:0] order_q    [n];
    logic [backend_pkg::xlen-1:0]    rs1_data_q [n];
    logic [backend_pkg::xlen-1:0]    rs2_data_q [n];
    logic [backend_pkg::xlen-1:0]    rd_data_q  [n];

    // the three buses gathered so they share one update loop
    logic [2:0]                        cdb_v;
    logic [backend_pkg::rob_idx_w-1:0] cdb_idx [3];
    logic [backend_pkg::xlen-1:0]      cdb_rs1 [3];
    logic [backend_pkg::xlen-1:0]      cdb_rs2 [3];
    logic [backend_pkg::xlen-1:0]      cdb_rd  [3];

    backend_pkg::opcode_t enq_op;

    assign cdb_v   = {div_cdb_valid, mul_cdb_valid, alu_cdb_valid};
    assign cdb_idx = '{alu_rob_idx, mul_rob_idx, div_rob_idx};
    assign cdb_rs1 = '{alu_rs1_rdata, mul_rs1_rdata, div_rs1_rdata};
    assign cdb_rs2 = '{alu_rs2_rdata, mul_rs2_rdata, div_rs2_rdata};
    assign cdb_rd  = '{alu_rd_wdata, mul_rd_wdata, div_rd_wdata};

    assign enq_op   = backend_pkg::opcode_t'(inst[6:0]);
    assign head_idx = head_ptr[backend_pkg::rob_idx_w-1:0];
    assign enq_idx  = tail_ptr[backend_pkg::rob_idx_w-1:0];
    assign full     = (head_ptr[backend_pkg::rob_idx_w] != tail_ptr[backend_pkg::rob_idx_w]) &&
                      (head_idx == enq_idx);

    // retire straight from the head entry, no handshake
    assign retire_valid     = valid_q[head_idx] && commit_q[head_idx];
    assign retire_order     = order_q[head_idx];
    assign retire_inst      = inst_q[head_idx];
    assign retire_rd_addr   = rd_q[head_idx];
    assign retire_rs1_addr  = rs1_q[head_idx];
    assign retire_rs2_addr  = rs2_q[head_idx];
    assign retire_rd_wdata  = rd_data_q[head_idx];
    assign retire_rs1_rdata = rs1_data_q[head_idx];
    assign retire_rs2_rdata = rs2_data_q[head_idx];
    assign retire_pd        = pd_q[head_idx];
    assign retire_pc_rdata  = pc_rdata_q[head_idx];
    assign retire_pc_wdata  = pc_wdata_q[head_idx];
    assign free_valid       = retire_valid && (old_pd_q[head_idx] != '0);  // p0 is never freed
    assign free_pd          = old_pd_q[head_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            valid_q  <= '0;
            commit_q <= '0;
        end else begin
            if (enq) begin
                valid_q[enq_idx]  <= 1'b1;
                commit_q[enq_idx] <= 1'b0;
                tail_ptr          <= tail_ptr + 1'b1;
            end
            if (retire_valid) begin
                valid_q[head_idx] <= 1'b0;
                head_ptr          <= head_ptr + 1'b1;
            end
            for (int i = 0; i < 3; i++) begin
                if (cdb_v[i]) commit_q[cdb_idx[i]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            pd_q[enq_idx]       <= pd;
            old_pd_q[enq_idx]   <= old_pd;
            rd_q[enq_idx]       <= rd;
            rs1_q[enq_idx]      <= (enq_op == backend_pkg::op_lui) ? '0 : rs1;
            rs2_q[enq_idx]      <= (enq_op == backend_pkg::op_lui ||
                                    enq_op == backend_pkg::op_imm) ? '0 : rs2;
            inst_q[enq_idx]     <= inst;
            pc_rdata_q[enq_idx] <= pc_rdata;
            pc_wdata_q[enq_idx] <= pc_wdata;
            order_q[enq_idx]    <= order;
        end
        for (int i = 0; i < 3; i++) begin
            if (cdb_v[i]) begin
                rs1_data_q[cdb_idx[i]] <= cdb_rs1[i];
                rs2_data_q[cdb_idx[i]] <= cdb_rs2[i];
                // canonical nop reports no writeback value
                rd_data_q[cdb_idx[i]]  <= (inst_q[cdb_idx[i]] == backend_pkg::nop_inst) ?
                                          '0 : cdb_rd[i];
            end
        end
    end

    // dispatch holds off while full
    assert property (@(posedge clk) disable iff (rst) enq |-> !full)
        else $error("rob enqueue while full");

    for (genvar g = 0; g < 3; g++) begin : g_cdb_chk
        // a bus may only complete a live, not yet finished entry
        assert property (@(posedge clk) disable iff (rst)
                         cdb_v[g] |-> valid_q[cdb_idx[g]] && !commit_q[cdb_idx[g]])
            else $error("completion bus %0d names a bad rob entry", g);
    end

endmodule

// ==== test/tb_backend.sv ====
`timescale 1ns/1ps

module tb_backend;

    localparam int max_insts   = 256;
    localparam int ack_limit   = 200;   // cycles
    localparam int drain_limit = 2000;

    logic        clk;
    logic        rst;
    logic        disp_req;
    logic        regf_we;
    logic [31:0] inst, pc_rdata, pc_wdata;
    logic [4:0]  rd, rs1, rs2;
    logic [63:0] order;
    logic        disp_ack;
    logic [3:0]  disp_rob_idx;
    logic [5:0]  disp_pd, disp_ps1, disp_ps2;
    logic        alu_cdb_valid, mul_cdb_valid, div_cdb_valid;
    logic [3:0]  alu_rob_idx, mul_rob_idx, div_rob_idx;
    logic [31:0] alu_rs1_rdata, alu_rs2_rdata, alu_rd_wdata;
    logic [31:0] mul_rs1_rdata, mul_rs2_rdata, mul_rd_wdata;
    logic [31:0] div_rs1_rdata, div_rs2_rdata, div_rd_wdata;
    logic        retire_valid;
    logic [63:0] retire_order;
    logic [31:0] retire_inst, retire_rd_wdata, retire_rs1_rdata, retire_rs2_rdata;
    logic [31:0] retire_pc_rdata, retire_pc_wdata;
    logic [4:0]  retire_rd_addr, retire_rs1_addr, retire_rs2_addr;
    logic [5:0]  retire_pd;

    // reference model
    logic [5:0]  map_ref  [32];
    logic [5:0]  free_ref [$];
    int          retire_q [$];  // seq numbers in program order
    int          pend_seq [$];  // dispatched but not yet completed
    logic [3:0]  pend_idx [$];
    logic [31:0] exp_inst [max_insts];
    logic [31:0] exp_pcr  [max_insts];
    logic [31:0] exp_rs1d [max_insts];
    logic [31:0] exp_rs2d [max_insts];
    logic [31:0] exp_rdd  [max_insts];
    logic [4:0]  exp_rd   [max_insts];
    logic [4:0]  exp_rs1  [max_insts];
    logic [4:0]  exp_rs2  [max_insts];
    logic [5:0]  exp_pd   [max_insts];
    logic [5:0]  exp_old  [max_insts];

    int seed;
    int disp_count;
    int retired;
    int dest_count;
    bit hold_complete;

    backend_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    // lui has no register sources
    function automatic logic [4:0] rs1_addr_seen(input logic [31:0] iw, input logic [4:0] a);
        return (iw[6:0] == backend_pkg::op_lui) ? 5'd0 : a;
    endfunction

    function automatic logic [4:0] rs2_addr_seen(input logic [31:0] iw, input logic [4:0] a);
        return (iw[6:0] == backend_pkg::op_lui || iw[6:0] == backend_pkg::op_imm) ? 5'd0 : a;
    endfunction

    function automatic logic [31:0] wdata_seen(input logic [31:0] iw, input logic [31:0] d);
        return (iw == backend_pkg::nop_inst) ? 32'd0 : d;  // nop writes nothing
    endfunction

    task automatic dispatch(input logic [31:0] iw, input logic [4:0] d, s1, s2,
                            input logic we, input bit expect_block);
        int          seq;
        int          n;
        int          retired_at_release;
        logic [5:0]  pd_e;
        logic [5:0]  old_e;
        logic [31:0] pcr;
        seq = disp_count;
        pcr = $random(seed);
        @(posedge clk);
        disp_req <= 1'b1;
        inst     <= iw;
        rd       <= d;
        rs1      <= s1;
        rs2      <= s2;
        regf_we  <= we;
        pc_rdata <= pcr;
        pc_wdata <= pcr + 32'd4;
        order    <= 64'h1000 + 64'(seq);
        retired_at_release = retired;
        if (expect_block) begin
            // rob is full, nothing may be accepted yet
            repeat (20) begin
                @(negedge clk);
                if (disp_ack) fail_now("disp_ack rose while the rob was full");
            end
            retired_at_release = retired;
            hold_complete = 1'b0;
        end
        n = 0;
        @(negedge clk);
        while (!disp_ack) begin
            n++;
            if (n > ack_limit) fail_now("timeout waiting for disp_ack");
            @(negedge clk);
        end
        if (expect_block && retired == retired_at_release) begin
            fail_now("a full rob accepted a dispatch before any entry retired");
        end
        check_eq("disp_rob_idx", disp_rob_idx, seq % 16);
        check_eq("disp_ps1", disp_ps1, map_ref[s1]);
        check_eq("disp_ps2", disp_ps2, map_ref[s2]);
        if (we && d != 5'd0) begin
            pd_e       = free_ref.pop_front();
            old_e      = map_ref[d];
            map_ref[d] = pd_e;
            dest_count++;
        end else begin
            pd_e  = 6'd0;
            old_e = 6'd0;
        end
        check_eq("disp_pd", disp_pd, pd_e);
        exp_inst[seq] = iw;
        exp_rd[seq]   = d;
        exp_rs1[seq]  = s1;
        exp_rs2[seq]  = s2;
        exp_pd[seq]   = pd_e;
        exp_old[seq]  = old_e;
        exp_pcr[seq]  = pcr;
        retire_q.push_back(seq);
        pend_seq.push_back(seq);
        pend_idx.push_back(disp_rob_idx);
        disp_count++;
        @(posedge clk);
        disp_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (disp_ack) begin
            n++;
            if (n > ack_limit) fail_now("timeout waiting for disp_ack to fall");
            @(negedge clk);
        end
    endtask

    task automatic dispatch_random(input bit expect_block);
        int          kind;
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [11:0] imm;
        logic [31:0] iw;
        logic        we;
        kind = $unsigned($random(seed)) % 6;
        d    = 5'($random(seed));
        s1   = 5'($random(seed));
        s2   = 5'($random(seed));
        imm  = 12'($random(seed)) | 12'h800;  // never the nop word
        we   = 1'b1;
        case (kind)
            0: iw = {imm, s1, 3'b000, d, backend_pkg::op_lui};
            1: iw = {imm, s1, 3'b000, d, backend_pkg::op_imm};
            2: iw = {7'b0, s2, s1, 3'b000, d, backend_pkg::op_reg};
            3: begin
                iw = {imm[11:5], s2, s1, 3'b010, imm[4:0], backend_pkg::op_store};
                we = 1'b0;
            end
            4: begin
                iw = {imm[11:5], s2, s1, 3'b000, imm[4:0], backend_pkg::op_br};
                we = 1'b0;
            end
            default: begin
                iw = backend_pkg::nop_inst;
                d  = 5'd0;
                s1 = 5'd0;
                s2 = 5'd0;
            end
        endcase
        dispatch(iw, d, s1, s2, we, expect_block);
    endtask

    task automatic drive_bus(input int k, input logic [3:0] idx, input logic [31:0] a, b, c);
        case (k)
            0: begin
                alu_cdb_valid <= 1'b1;
                alu_rob_idx   <= idx;
                alu_rs1_rdata <= a;
                alu_rs2_rdata <= b;
                alu_rd_wdata  <= c;
            end
            1: begin
                mul_cdb_valid <= 1'b1;
                mul_rob_idx   <= idx;
                mul_rs1_rdata <= a;
                mul_rs2_rdata <= b;
                mul_rd_wdata  <= c;
            end
            default: begin
                div_cdb_valid <= 1'b1;
                div_rob_idx   <= idx;
                div_rs1_rdata <= a;
                div_rs2_rdata <= b;
                div_rd_wdata  <= c;
            end
        endcase
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (retire_q.size() != 0) begin
            n++;
            if (n > drain_limit) fail_now("timeout waiting for the rob to drain");
            @(negedge clk);
        end
    endtask

    // completes outstanding entries in random order on random buses
    initial begin : completion
        int          k;
        int          pick;
        int          s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        forever begin
            @(posedge clk);
            alu_cdb_valid <= 1'b0;
            mul_cdb_valid <= 1'b0;
            div_cdb_valid <= 1'b0;
            for (k = 0; k < 3; k++) begin
                if (!rst && !hold_complete && pend_seq.size() > 0 && $random(seed) % 2 == 0) begin
                    pick = $unsigned($random(seed)) % pend_seq.size();
                    s    = pend_seq[pick];
                    a    = $random(seed);
                    b    = $random(seed);
                    c    = $random(seed);
                    exp_rs1d[s] = a;
                    exp_rs2d[s] = b;
                    exp_rdd[s]  = c;
                    drive_bus(k, pend_idx[pick], a, b, c);
                    pend_seq.delete(pick);
                    pend_idx.delete(pick);
                end
            end
        end
    end

    initial begin : compare
        int s;
        forever begin
            @(negedge clk);
            if (!rst && retire_valid) begin
                if (retire_q.size() == 0) fail_now("retirement with nothing outstanding");
                s = retire_q.pop_front();
                check_eq("retire_order", retire_order, 64'h1000 + 64'(s));
                check_eq("retire_inst", retire_inst, exp_inst[s]);
                check_eq("retire_rd_addr", retire_rd_addr, exp_rd[s]);
                check_eq("retire_rs1_addr", retire_rs1_addr,
                         rs1_addr_seen(exp_inst[s], exp_rs1[s]));
                check_eq("retire_rs2_addr", retire_rs2_addr,
                         rs2_addr_seen(exp_inst[s], exp_rs2[s]));
                check_eq("retire_rd_wdata", retire_rd_wdata, wdata_seen(exp_inst[s], exp_rdd[s]));
                check_eq("retire_rs1_rdata", retire_rs1_rdata, exp_rs1d[s]);
                check_eq("retire_rs2_rdata", retire_rs2_rdata, exp_rs2d[s]);
                check_eq("retire_pd", retire_pd, exp_pd[s]);
                check_eq("retire_pc_rdata", retire_pc_rdata, exp_pcr[s]);
                check_eq("retire_pc_wdata", retire_pc_wdata, exp_pcr[s] + 32'd4);
                if (exp_old[s] != 6'd0) free_ref.push_back(exp_old[s]);  // freed at this edge
                retired++;
            end
        end
    end

    initial begin : main
        int n;
        seed          = 16;
        rst           = 1'b1;
        disp_req      = 1'b0;
        inst          = 32'd0;
        rd            = 5'd0;
        rs1           = 5'd0;
        rs2           = 5'd0;
        regf_we       = 1'b0;
        pc_rdata      = 32'd0;
        pc_wdata      = 32'd0;
        order         = 64'd0;
        alu_cdb_valid = 1'b0;
        alu_rob_idx   = 4'd0;
        alu_rs1_rdata = 32'd0;
        alu_rs2_rdata = 32'd0;
        alu_rd_wdata  = 32'd0;
        mul_cdb_valid = 1'b0;
        mul_rob_idx   = 4'd0;
        mul_rs1_rdata = 32'd0;
        mul_rs2_rdata = 32'd0;
        mul_rd_wdata  = 32'd0;
        div_cdb_valid = 1'b0;
        div_rob_idx   = 4'd0;
        div_rs1_rdata = 32'd0;
        div_rs2_rdata = 32'd0;
        div_rd_wdata  = 32'd0;
        hold_complete = 1'b0;
        for (n = 0; n < 32; n++) begin
            map_ref[n] = 6'(n);
            free_ref.push_back(6'(32 + n));
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // field rules and no-destination cases first
        dispatch({20'h12345, 5'd3, backend_pkg::op_lui}, 5'd3, 5'd7, 5'd9, 1'b1, 1'b0);
        dispatch({12'h801, 5'd3, 3'b000, 5'd4, backend_pkg::op_imm}, 5'd4, 5'd3, 5'd11,
                 1'b1, 1'b0);
        dispatch(backend_pkg::nop_inst, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0);
        dispatch({7'b0, 5'd2, 5'd1, 3'b000, 5'd0, backend_pkg::op_reg}, 5'd0, 5'd1, 5'd2,
                 1'b1, 1'b0);
        dispatch({7'b0, 5'd4, 5'd3, 3'b010, 5'd8, backend_pkg::op_store}, 5'd8, 5'd3, 5'd4,
                 1'b0, 1'b0);

        repeat (100) dispatch_random(1'b0);
        wait_drain();
        check_eq("destinations allocated above 32", dest_count > 32, 1);

        // fill the rob, then the 17th must wait for a retirement
        hold_complete = 1'b1;
        repeat (16) dispatch_random(1'b0);
        dispatch_random(1'b1);
        wait_drain();

        $display("Test passed");
        $finish;
    end

endmodule
